//--- dcache_data_stage.f
+incdir+.
dcache_pkg.sv
dcache_ifs.sv
dcache_data_array.sv
dcache_way_hit.sv
dcache_store_format.sv
dcache_stage_commit.sv
dcache_data_stage.sv
tb_dcache_clock.sv
tb_dcache_data_stage.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the data stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_dcache_data_stage -f dcache_data_stage.f \
    -Mdir obj_dir -o sim_tb \
    && sim_out="$(./obj_dir/sim_tb)" \
    && echo "$sim_out" \
    && grep -qx "TB PASSED" <<< "$sim_out" \
    && echo "simulation passed" \
    || { echo "simulation did not pass"; exit 1; }

//--- tb_dcache_data_stage.sv
////////////////////
// Testbench for the data stage with tag model,
// stimulus, assertions and reporting
////////////////////

`timescale 1ns/1ps

`include "dcache_cfg.svh"

module tb_dcache_data_stage;
    import dcache_pkg::*;

    logic clk;
    logic reset;
    logic req_valid;
    logic req_is_load;
    access_size_t req_size;
    scalar_t req_paddr;
    scalar_t req_store_value;
    logic [`DCACHE_WAYS - 1:0] tag_valid;
    l1d_tag_t tag_way[`DCACHE_WAYS];
    logic fill_en;
    l1d_way_idx_t fill_way;
    l1d_set_idx_t fill_set;
    cache_line_data_t fill_data;
    logic update_lru_en;
    l1d_way_idx_t update_lru_way;
    logic cache_miss;
    cache_line_index_t cache_miss_addr;
    logic store_en;
    cache_line_index_t store_addr;
    line_byte_mask_t store_mask;
    cache_line_data_t store_data;
    logic resp_valid;
    cache_line_data_t load_data;
    logic suspend_thread;
    logic fault;
    logic fault_is_store;

    // Tag stage state and array contents as the testbench sees them
    logic model_valid[`DCACHE_WAYS][`DCACHE_SETS];
    l1d_tag_t model_tag[`DCACHE_WAYS][`DCACHE_SETS];
    cache_line_data_t model_line[`DCACHE_WAYS][`DCACHE_SETS];

    // Expected values in the request cycle
    logic chk_comb;
    logic exp_lru_en;
    l1d_way_idx_t exp_lru_way;
    logic exp_miss;
    logic exp_store_en;
    cache_line_index_t exp_line;
    line_byte_mask_t exp_mask;
    cache_line_data_t exp_data;
    logic exp_suspend;
    logic exp_fault;
    logic exp_fault_is_store;
    logic exp_load;
    cache_line_data_t exp_load_data;

    // Same expectations, one cycle later for the registered outputs
    logic chk_reg;
    logic reg_suspend;
    logic reg_fault;
    logic reg_fault_is_store;
    logic reg_load;
    cache_line_data_t reg_load_data;

    integer seed;
    int error_count;
    int errors_at_start;
    int tests_passed;
    int tests_failed;
    string test_name;

    tb_dcache_clock i_clock
    (
        .clk(clk),
        .reset(reset)
    );

    dcache_data_stage i_dcache_data_stage
    (
        .clk(clk),
        .reset(reset),
        .req_valid(req_valid),
        .req_is_load(req_is_load),
        .req_size(req_size),
        .req_paddr(req_paddr),
        .req_store_value(req_store_value),
        .tag_valid(tag_valid),
        .tag_way(tag_way),
        .fill_en(fill_en),
        .fill_way(fill_way),
        .fill_set(fill_set),
        .fill_data(fill_data),
        .update_lru_en(update_lru_en),
        .update_lru_way(update_lru_way),
        .cache_miss(cache_miss),
        .cache_miss_addr(cache_miss_addr),
        .store_en(store_en),
        .store_addr(store_addr),
        .store_mask(store_mask),
        .store_data(store_data),
        .resp_valid(resp_valid),
        .load_data(load_data),
        .suspend_thread(suspend_thread),
        .fault(fault),
        .fault_is_store(fault_is_store)
    );

    always_ff @(posedge clk)
    begin
        chk_reg <= chk_comb;
        reg_suspend <= exp_suspend;
        reg_fault <= exp_fault;
        reg_fault_is_store <= exp_fault_is_store;
        reg_load <= exp_load;
        reg_load_data <= exp_load_data;
    end

    task automatic flag_mismatch(input string what, input logic [511:0] expected,
                                 input logic [511:0] actual);
        error_count++;
        $display("ERROR %s: %s expected %0h actual %0h", test_name, what, expected, actual);
    endtask

    // Outputs are sampled on the falling edge, halfway between drive points
    a_lru_en: assert property (@(negedge clk) disable iff (reset)
        chk_comb |-> update_lru_en == exp_lru_en)
        else flag_mismatch("update_lru_en", 512'(exp_lru_en), 512'(update_lru_en));
    a_lru_way: assert property (@(negedge clk) disable iff (reset)
        chk_comb && exp_lru_en |-> update_lru_way == exp_lru_way)
        else flag_mismatch("update_lru_way", 512'(exp_lru_way), 512'(update_lru_way));
    a_miss: assert property (@(negedge clk) disable iff (reset)
        chk_comb |-> cache_miss == exp_miss)
        else flag_mismatch("cache_miss", 512'(exp_miss), 512'(cache_miss));
    a_miss_addr: assert property (@(negedge clk) disable iff (reset)
        chk_comb && exp_miss |-> cache_miss_addr == exp_line)
        else flag_mismatch("cache_miss_addr", 512'(exp_line), 512'(cache_miss_addr));
    a_store_en: assert property (@(negedge clk) disable iff (reset)
        chk_comb |-> store_en == exp_store_en)
        else flag_mismatch("store_en", 512'(exp_store_en), 512'(store_en));
    a_store_addr: assert property (@(negedge clk) disable iff (reset)
        chk_comb && exp_store_en |-> store_addr == exp_line)
        else flag_mismatch("store_addr", 512'(exp_line), 512'(store_addr));
    a_store_mask: assert property (@(negedge clk) disable iff (reset)
        chk_comb && exp_store_en |-> store_mask == exp_mask)
        else flag_mismatch("store_mask", 512'(exp_mask), 512'(store_mask));
    a_store_data: assert property (@(negedge clk) disable iff (reset)
        chk_comb && exp_store_en |-> store_data == exp_data)
        else flag_mismatch("store_data", exp_data, store_data);
    a_resp_valid: assert property (@(negedge clk) disable iff (reset)
        chk_reg |-> resp_valid)
        else flag_mismatch("resp_valid", 512'(1), 512'(resp_valid));
    a_suspend: assert property (@(negedge clk) disable iff (reset)
        chk_reg |-> suspend_thread == reg_suspend)
        else flag_mismatch("suspend_thread", 512'(reg_suspend), 512'(suspend_thread));
    a_fault: assert property (@(negedge clk) disable iff (reset)
        chk_reg |-> fault == reg_fault)
        else flag_mismatch("fault", 512'(reg_fault), 512'(fault));
    a_fault_is_store: assert property (@(negedge clk) disable iff (reset)
        chk_reg && reg_fault |-> fault_is_store == reg_fault_is_store)
        else flag_mismatch("fault_is_store", 512'(reg_fault_is_store), 512'(fault_is_store));
    a_load_data: assert property (@(negedge clk) disable iff (reset)
        chk_reg && reg_load |-> load_data == reg_load_data)
        else flag_mismatch("load_data", reg_load_data, load_data);

    function automatic int access_bytes(input access_size_t size);
        if (size == `ACCESS_BYTE)
            return 1;
        else if (size == `ACCESS_HALF)
            return 2;
        return 4;
    endfunction

    // Mask bit 63 minus o covers line byte o
    function automatic line_byte_mask_t expected_mask(input access_size_t size, input int offset);
        line_byte_mask_t mask;
        int count;
        int first;
        count = access_bytes(size);
        first = offset - offset % count;
        mask = '0;
        for (int i = 0; i < `CACHE_LINE_BYTES; i++)
            mask[`CACHE_LINE_BYTES - 1 - i] = i >= first && i < first + count;
        return mask;
    endfunction

    // Big-endian, the most significant value byte lands at the lowest address
    function automatic cache_line_data_t expected_data(input access_size_t size,
                                                       input scalar_t value);
        cache_line_data_t data;
        int count;
        int lane;
        count = access_bytes(size);
        for (int i = 0; i < `CACHE_LINE_BYTES; i++)
        begin
            lane = count - 1 - i % count;
            data[(`CACHE_LINE_BYTES - 1 - i) * 8 +: 8] = value[lane * 8 +: 8];
        end
        return data;
    endfunction

    function automatic logic expected_fault(input access_size_t size, input int offset);
        return (size == `ACCESS_HALF && offset % 2 != 0) ||
            (size == `ACCESS_WORD && offset % 4 != 0);
    endfunction

    function automatic cache_line_data_t random_line();
        cache_line_data_t line;
        for (int i = 0; i < `CACHE_LINE_WORDS; i++)
            line[i * 32 +: 32] = $random(seed);
        return line;
    endfunction

    task automatic step();
        @(posedge clk);
        #1;
        req_valid = 1'b0;
        fill_en = 1'b0;
        chk_comb = 1'b0;
    endtask

    task automatic start_fill(input l1d_way_idx_t way, input l1d_set_idx_t set,
                              input l1d_tag_t tag, input cache_line_data_t line);
        fill_en = 1'b1;
        fill_way = way;
        fill_set = set;
        fill_data = line;
        // A line lives in one way only
        for (int w = 0; w < `DCACHE_WAYS; w++)
        begin
            if (model_valid[w][set] && model_tag[w][set] == tag)
                model_valid[w][set] = 1'b0;
        end
        model_valid[way][set] = 1'b1;
        model_tag[way][set] = tag;
        model_line[way][set] = line;
    endtask

    task automatic send_request(input logic is_load, input access_size_t size,
                                input scalar_t paddr, input scalar_t value);
        l1d_set_idx_t set;
        l1d_way_idx_t way;
        logic hit;
        logic bad;
        set = paddr[11:6];
        way = '0;
        hit = 1'b0;
        for (int w = 0; w < `DCACHE_WAYS; w++)
        begin
            tag_valid[w] = model_valid[w][set];
            tag_way[w] = model_tag[w][set];
            if (model_valid[w][set] && model_tag[w][set] == paddr[31:12])
            begin
                hit = 1'b1;
                way = l1d_way_idx_t'(w);
            end
        end
        bad = expected_fault(size, int'(paddr[5:0]));
        req_valid = 1'b1;
        req_is_load = is_load;
        req_size = size;
        req_paddr = paddr;
        req_store_value = value;
        chk_comb = 1'b1;
        exp_lru_en = is_load && hit && !bad;
        exp_lru_way = way;
        exp_miss = is_load && !hit && !bad;
        exp_store_en = !is_load && !bad;
        exp_line = paddr[31:6];
        exp_mask = expected_mask(size, int'(paddr[5:0]));
        exp_data = expected_data(size, value);
        exp_suspend = exp_miss;
        exp_fault = bad;
        exp_fault_is_store = !is_load;
        exp_load = exp_lru_en;
        exp_load_data = model_line[way][set];
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        errors_at_start = error_count;
    endtask

    // Two idle cycles let the registered checks of the last request run
    task automatic end_test();
        step();
        step();
        if (error_count == errors_at_start)
        begin
            tests_passed++;
            $display("test %s: ok", test_name);
        end
        else
        begin
            tests_failed++;
            $display("test %s: %0d errors", test_name, error_count - errors_at_start);
        end
    endtask

    task automatic run_tests();
        scalar_t addr;
        l1d_way_idx_t way;
        access_size_t size;

        begin_test("load_hit");
        for (int i = 0; i < 4; i++)
        begin
            way = l1d_way_idx_t'($random(seed));
            addr = $random(seed);
            addr[1:0] = 2'b00;
            start_fill(way, addr[11:6], addr[31:12], random_line());
            step();
            send_request(1'b1, `ACCESS_WORD, addr, 32'h0);
            step();
        end
        end_test();

        begin_test("load_miss");
        for (int i = 0; i < 4; i++)
        begin
            addr = $random(seed);
            addr[1:0] = 2'b00;
            for (int w = 0; w < `DCACHE_WAYS; w++)
                model_valid[w][addr[11:6]] = 1'b0;
            send_request(1'b1, `ACCESS_WORD, addr, 32'h0);
            step();
        end
        end_test();

        begin_test("store_format");
        for (int i = 0; i < 12; i++)
        begin
            size = access_size_t'(i % 3);
            addr = $random(seed);
            if (size == `ACCESS_HALF)
                addr[0] = 1'b0;
            if (size == `ACCESS_WORD)
                addr[1:0] = 2'b00;
            send_request(1'b0, size, addr, $random(seed));
            step();
        end
        end_test();

        begin_test("align_fault");
        addr = $random(seed);
        addr[0] = 1'b1;
        send_request(1'b0, `ACCESS_HALF, addr, $random(seed));
        step();
        addr = $random(seed);
        addr[5:0] = 6'd2;
        send_request(1'b1, `ACCESS_WORD, addr, 32'h0);
        step();
        end_test();

        // Refill of a resident line in the same cycle as its load
        begin_test("fill_collision");
        for (int i = 0; i < 3; i++)
        begin
            way = l1d_way_idx_t'($random(seed));
            addr = $random(seed);
            addr[1:0] = 2'b00;
            start_fill(way, addr[11:6], addr[31:12], random_line());
            step();
            start_fill(way, addr[11:6], addr[31:12], random_line());
            send_request(1'b1, `ACCESS_WORD, addr, 32'h0);
            step();
        end
        end_test();
    endtask

    initial
    begin
        int cycles;
        seed = 32'h8dd4_897f;
        error_count = 0;
        errors_at_start = 0;
        tests_passed = 0;
        tests_failed = 0;
        test_name = "reset";
        req_valid = 1'b0;
        req_is_load = 1'b0;
        req_size = '0;
        req_paddr = '0;
        req_store_value = '0;
        tag_valid = '0;
        fill_en = 1'b0;
        fill_way = '0;
        fill_set = '0;
        fill_data = '0;
        chk_comb = 1'b0;
        for (int w = 0; w < `DCACHE_WAYS; w++)
        begin
            tag_way[w] = '0;
            for (int s = 0; s < `DCACHE_SETS; s++)
            begin
                model_valid[w][s] = 1'b0;
                model_tag[w][s] = '0;
                model_line[w][s] = '0;
            end
        end

        cycles = 0;
        while (reset && cycles < 20)
        begin
            @(posedge clk);
            cycles++;
        end
        if (reset)
        begin
            $display("timeout: reset still asserted after %0d cycles", cycles);
            $display("TB FAILED");
            $finish;
        end
        else
        begin
            #1;
            run_tests();
            $display("tests passed %0d, failed %0d, assertion errors %0d",
                tests_passed, tests_failed, error_count);
            if (tests_failed == 0 && error_count == 0)
                $display("TB PASSED");
            else
                $display("TB FAILED");
            $finish;
        end
    end
endmodule

//--- tb_dcache_clock.sv
////////////////////
// Testbench clock and reset generator
////////////////////

`timescale 1ns/1ps

module tb_dcache_clock
(
    output logic clk,
    output logic reset
);
    // 10 ns period
    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Reset covers five rising edges, released on a falling edge
    initial
    begin
        reset = 1'b1;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end
endmodule

//--- dcache_data_stage.sv
////////////////////
// L1 data cache data stage, top level
////////////////////

`timescale 1ns/1ps

`include "dcache_cfg.svh"

module dcache_data_stage
(
    input logic clk,
    input logic reset,

    // Request from the tag stage
    input logic req_valid,
    input logic req_is_load,
    input dcache_pkg::access_size_t req_size,
    input dcache_pkg::scalar_t req_paddr,
    input dcache_pkg::scalar_t req_store_value,
    input logic [`DCACHE_WAYS - 1:0] tag_valid,
    input dcache_pkg::l1d_tag_t tag_way[`DCACHE_WAYS],

    // Fill from L2
    input logic fill_en,
    input dcache_pkg::l1d_way_idx_t fill_way,
    input dcache_pkg::l1d_set_idx_t fill_set,
    input dcache_pkg::cache_line_data_t fill_data,

    output logic update_lru_en,
    output dcache_pkg::l1d_way_idx_t update_lru_way,
    output logic cache_miss,
    output dcache_pkg::cache_line_index_t cache_miss_addr,
    output logic store_en,
    output dcache_pkg::cache_line_index_t store_addr,
    output dcache_pkg::line_byte_mask_t store_mask,
    output dcache_pkg::cache_line_data_t store_data,
    output logic resp_valid,
    output dcache_pkg::cache_line_data_t load_data,
    output logic suspend_thread,
    output logic fault,
    output logic fault_is_store
);
    mem_req_if req_bus();
    hit_result_if hit_bus();

    logic unaligned;

    assign req_bus.valid = req_valid;
    assign req_bus.is_load = req_is_load;
    assign req_bus.size = req_size;
    assign req_bus.paddr = req_paddr;
    assign req_bus.store_value = req_store_value;

    dcache_way_hit i_way_hit
    (
        .clk(clk),
        .reset(reset),
        .req(req_bus.sink),
        .tag_valid(tag_valid),
        .tag_way(tag_way),
        .fill_en(fill_en),
        .fill_way(fill_way),
        .fill_set(fill_set),
        .fill_data(fill_data),
        .result(hit_bus.producer),
        .load_data(load_data)
    );

    dcache_store_format i_store_format
    (
        .req(req_bus.sink),
        .store_mask(store_mask),
        .store_data(store_data),
        .unaligned(unaligned)
    );

    dcache_stage_commit i_stage_commit
    (
        .clk(clk),
        .reset(reset),
        .req(req_bus.sink),
        .result(hit_bus.consumer),
        .unaligned(unaligned),
        .store_mask_in(store_mask),
        .update_lru_en(update_lru_en),
        .update_lru_way(update_lru_way),
        .cache_miss(cache_miss),
        .cache_miss_addr(cache_miss_addr),
        .store_en(store_en),
        .store_addr(store_addr),
        .resp_valid(resp_valid),
        .suspend_thread(suspend_thread),
        .fault(fault),
        .fault_is_store(fault_is_store)
    );
endmodule

//--- dcache_stage_commit.sv
////////////////////
// Miss, store, LRU and fault decode with response register
////////////////////

`timescale 1ns/1ps

module dcache_stage_commit
(
    input logic clk,
    input logic reset,
    mem_req_if.sink req,
    hit_result_if.consumer result,
    input logic unaligned,
    input dcache_pkg::line_byte_mask_t store_mask_in,
    output logic update_lru_en,
    output dcache_pkg::l1d_way_idx_t update_lru_way,
    output logic cache_miss,
    output dcache_pkg::cache_line_index_t cache_miss_addr,
    output logic store_en,
    output dcache_pkg::cache_line_index_t store_addr,
    output logic resp_valid,
    output logic suspend_thread,
    output logic fault,
    output logic fault_is_store
);
    logic store_req;

    assign store_req = req.valid && !req.is_load;

    // An unaligned access has no side effects, it only faults
    assign cache_miss = result.load_en && !result.hit && !unaligned;
    assign cache_miss_addr = req.paddr[31:6];

    assign store_en = store_req && !unaligned && |store_mask_in;
    assign store_addr = req.paddr[31:6];

    assign update_lru_en = result.load_en && result.hit && !unaligned;
    assign update_lru_way = result.hit_way;

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            resp_valid <= 1'b0;
            suspend_thread <= 1'b0;
            fault <= 1'b0;
            fault_is_store <= 1'b0;
        end
        else
        begin
            resp_valid <= req.valid;
            // Thread sleeps until the L2 fill for the missed line returns
            suspend_thread <= cache_miss;
            fault <= req.valid && unaligned;
            fault_is_store <= !req.is_load;
        end
    end

    a_single_action: assert property (@(posedge clk) disable iff (reset)
        $onehot0({cache_miss, store_en, update_lru_en}));
endmodule

//--- dcache_store_format.sv
////////////////////
// Store byte mask, replicated store data, alignment check
////////////////////

`timescale 1ns/1ps

`include "dcache_cfg.svh"

module dcache_store_format
(
    mem_req_if.sink req,
    output dcache_pkg::line_byte_mask_t store_mask,
    output dcache_pkg::cache_line_data_t store_data,
    output logic unaligned
);
    import dcache_pkg::*;

    logic [$clog2(`CACHE_LINE_BYTES) - 1:0] offset;
    line_byte_mask_t first_byte;
    line_byte_mask_t first_half;
    line_byte_mask_t first_word;

    assign offset = req.paddr[$clog2(`CACHE_LINE_BYTES) - 1:0];

    // Patterns for an access at line byte 0, the top mask bit
    assign first_byte = {1'b1, {(`CACHE_LINE_BYTES - 1){1'b0}}};
    assign first_half = {2'b11, {(`CACHE_LINE_BYTES - 2){1'b0}}};
    assign first_word = {4'b1111, {(`CACHE_LINE_BYTES - 4){1'b0}}};

    // Line byte 0 sits in the top bits, so plain replication is big-endian
    always_comb
    begin
        case (req.size)
            `ACCESS_BYTE:
            begin
                store_mask = first_byte >> offset;
                store_data = {`CACHE_LINE_BYTES{req.store_value[7:0]}};
            end

            `ACCESS_HALF:
            begin
                store_mask = first_half >> {offset[$bits(offset) - 1:1], 1'b0};
                store_data = {(`CACHE_LINE_WORDS * 2){req.store_value[15:0]}};
            end

            `ACCESS_WORD:
            begin
                store_mask = first_word >> {offset[$bits(offset) - 1:2], 2'b00};
                store_data = {`CACHE_LINE_WORDS{req.store_value}};
            end

            default:
            begin
                store_mask = '0;
                store_data = '0;
            end
        endcase
    end

    always_comb
    begin
        case (req.size)
            `ACCESS_HALF: unaligned = offset[0];
            `ACCESS_WORD: unaligned = |offset[1:0];
            default: unaligned = 1'b0;
        endcase
    end
endmodule

//--- dcache_way_hit.sv
////////////////////
// Tag compare across ways, hit way encode, line read
////////////////////

`timescale 1ns/1ps

`include "dcache_cfg.svh"

module dcache_way_hit
(
    input logic clk,
    input logic reset,
    mem_req_if.sink req,
    input logic [`DCACHE_WAYS - 1:0] tag_valid,
    input dcache_pkg::l1d_tag_t tag_way[`DCACHE_WAYS],
    input logic fill_en,
    input dcache_pkg::l1d_way_idx_t fill_way,
    input dcache_pkg::l1d_set_idx_t fill_set,
    input dcache_pkg::cache_line_data_t fill_data,
    hit_result_if.producer result,
    output dcache_pkg::cache_line_data_t load_data
);
    import dcache_pkg::*;

    l1d_tag_t req_tag;
    l1d_set_idx_t req_set;
    logic [`DCACHE_WAYS - 1:0] way_hit_oh;
    l1d_way_idx_t hit_way_idx;

    assign req_tag = req.paddr[31:12];
    assign req_set = req.paddr[11:6];

    always_comb
    begin
        for (int w = 0; w < `DCACHE_WAYS; w++)
            way_hit_oh[w] = tag_valid[w] && tag_way[w] == req_tag;
    end

    // One-hot to index, assumes at most one way holds the line
    always_comb
    begin
        hit_way_idx = '0;
        for (int w = 0; w < `DCACHE_WAYS; w++)
        begin
            if (way_hit_oh[w])
                hit_way_idx = l1d_way_idx_t'(w);
        end
    end

    assign result.load_en = req.valid && req.is_load;
    assign result.hit = |way_hit_oh;
    assign result.hit_way = hit_way_idx;
    assign result.way_hit_oh = way_hit_oh;

    // Only a hitting load reads the array
    dcache_data_array i_data_array
    (
        .clk(clk),
        .reset(reset),
        .read_en(result.load_en && result.hit),
        .read_way(hit_way_idx),
        .read_set(req_set),
        .read_data(load_data),
        .write_en(fill_en),
        .write_way(fill_way),
        .write_set(fill_set),
        .write_data(fill_data)
    );

    // Tag stage must never present the same line in two ways
    a_way_hit_onehot: assert property (@(posedge clk) disable iff (reset)
        result.load_en |-> $onehot0(way_hit_oh));
endmodule

//--- dcache_data_array.sv
////////////////////
// Line storage with one read and one write port
////////////////////

`timescale 1ns/1ps

`include "dcache_cfg.svh"

module dcache_data_array
(
    input logic clk,
    input logic reset,
    input logic read_en,
    input dcache_pkg::l1d_way_idx_t read_way,
    input dcache_pkg::l1d_set_idx_t read_set,
    output dcache_pkg::cache_line_data_t read_data,
    input logic write_en,
    input dcache_pkg::l1d_way_idx_t write_way,
    input dcache_pkg::l1d_set_idx_t write_set,
    input dcache_pkg::cache_line_data_t write_data
);
    import dcache_pkg::*;

    cache_line_data_t lines[`DCACHE_WAYS][`DCACHE_SETS];
    logic same_entry;

    assign same_entry = write_en && write_way == read_way && write_set == read_set;

    always_ff @(posedge clk)
    begin
        if (write_en)
            lines[write_way][write_set] <= write_data;
    end

    // Fill data bypasses the array when both ports hit one entry
    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
            read_data <= '0;
        else if (read_en)
            read_data <= same_entry ? write_data : lines[read_way][read_set];
    end
endmodule

//--- dcache_ifs.sv
////////////////////
// Request bus and hit result bus of the data stage
////////////////////

`timescale 1ns/1ps

`include "dcache_cfg.svh"

// One scalar memory request, taken whenever valid is high
interface mem_req_if;
    import dcache_pkg::*;

    logic valid;
    logic is_load;
    access_size_t size;
    scalar_t paddr;
    scalar_t store_value;

    modport source
    (
        output valid,
        output is_load,
        output size,
        output paddr,
        output store_value
    );

    modport sink
    (
        input valid,
        input is_load,
        input size,
        input paddr,
        input store_value
    );
endinterface

// Hit information, hit only means something while load_en is high
interface hit_result_if;
    import dcache_pkg::*;

    logic load_en;
    logic hit;
    l1d_way_idx_t hit_way;
    logic [`DCACHE_WAYS - 1:0] way_hit_oh;

    modport producer
    (
        output load_en,
        output hit,
        output hit_way,
        output way_hit_oh
    );

    modport consumer
    (
        input load_en,
        input hit,
        input hit_way,
        input way_hit_oh
    );
endinterface

//--- dcache_pkg.sv
////////////////////
// Shared vector types for the L1 data stage
////////////////////

`include "dcache_cfg.svh"

package dcache_pkg;

    typedef logic [31:0] scalar_t;

    // Address split is tag | set | line offset
    typedef logic [31 - $clog2(`DCACHE_SETS) - $clog2(`CACHE_LINE_BYTES):0] l1d_tag_t;
    typedef logic [$clog2(`DCACHE_SETS) - 1:0] l1d_set_idx_t;
    typedef logic [$clog2(`DCACHE_WAYS) - 1:0] l1d_way_idx_t;

    // Tag and set together
    typedef logic [31 - $clog2(`CACHE_LINE_BYTES):0] cache_line_index_t;

    typedef logic [`CACHE_LINE_BYTES * 8 - 1:0] cache_line_data_t;

    // Bit 63 covers line byte 0
    typedef logic [`CACHE_LINE_BYTES - 1:0] line_byte_mask_t;

    typedef logic [1:0] access_size_t;

endpackage

//--- dcache_cfg.svh
////////////////////
// Cache geometry and access-size codes for the L1 data stage
////////////////////

`ifndef DCACHE_CFG_SVH
`define DCACHE_CFG_SVH

// Geometry
`define DCACHE_WAYS 4
`define DCACHE_SETS 64
`define CACHE_LINE_BYTES 64
`define CACHE_LINE_WORDS 16

// Scalar access sizes as carried on mem_req_if.size
`define ACCESS_BYTE 2'd0
`define ACCESS_HALF 2'd1
`define ACCESS_WORD 2'd2

`endif
